//--- rtl/div_settings.svh
`ifndef DIV_SETTINGS_SVH
`define DIV_SETTINGS_SVH

// operand and result width of the RV64 datapath
`define DIV_XLEN 64

// width of the DIVW/DIVUW/REMW/REMUW operations
`define DIV_WLEN 32

// iteration counter width, holds the value DIV_XLEN
`define DIV_CNT_W 7

`endif

//--- rtl/div_op_pkg.sv
package div_op_pkg;

  // decoded divide request flags, taken from the execute stage
  // is_signed selects DIV/REM over DIVU/REMU
  // is_word selects the 32-bit W variants
  typedef struct packed {
    logic is_signed;
    logic is_word;
  } div_op_t;

endpackage

//--- rtl/div_status_pkg.sv
package div_status_pkg;

  // iterative core sequencing
  typedef enum logic [1:0] {
    CORE_IDLE = 2'd0,
    CORE_RUN  = 2'd1,
    CORE_DONE = 2'd2
  } core_state_e;

  // operands that bypass the shift-subtract result
  typedef enum logic [1:0] {
    SPECIAL_NONE     = 2'd0,
    SPECIAL_DIV_ZERO = 2'd1,
    SPECIAL_OVERFLOW = 2'd2
  } special_kind_e;

endpackage

//--- rtl/div_mag_if.sv
`timescale 1ns/1ps
`include "div_settings.svh"

interface div_mag_if;

  // one-cycle launch pulse from the top
  logic                 start;
  // operation flags, held by the requester for the whole operation
  div_op_pkg::div_op_t  op;

  // core status and signed results
  logic                 busy;
  logic [`DIV_XLEN-1:0] quotient;
  logic [`DIV_XLEN-1:0] remainder;
  // quotient and remainder are final while done is high
  logic                 done;

  modport core   (input start, input op, output busy, output quotient,
                  output remainder, output done);

  modport detect (input start, input op);

  modport fix    (input op, input quotient, input remainder, input done);

endinterface

//--- rtl/div_iter_core.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_iter_core (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  div_mag_if.core              mag
);

  div_status_pkg::core_state_e state_q;

  // iterations left, zero means the sign fix-up cycle
  logic [`DIV_CNT_W-1:0] cnt_q;

  // result signs recorded at load
  logic q_neg_q;
  logic r_neg_q;

  // partial remainder, dividend/quotient shift register and divisor magnitude
  logic [`DIV_XLEN-1:0] rem_q;
  logic [`DIV_XLEN-1:0] quo_q;
  logic [`DIV_XLEN-1:0] div_q;

  // operands extended to full width according to the operation
  logic [`DIV_XLEN-1:0] a_ext;
  logic [`DIV_XLEN-1:0] b_ext;
  logic                 a_neg;
  logic                 b_neg;
  logic [`DIV_XLEN-1:0] a_mag;
  logic [`DIV_XLEN-1:0] b_mag;

  // one restoring step
  logic [`DIV_XLEN:0]   shifted;
  logic [`DIV_XLEN:0]   trial;

  // word operands keep only the low half
  // signed word operands are sign extended so one negation serves both widths
  always_comb begin
    if (mag.op.is_word) begin
      a_ext = {{(`DIV_XLEN-`DIV_WLEN){mag.op.is_signed & dividend_i[`DIV_WLEN-1]}},
               dividend_i[`DIV_WLEN-1:0]};
      b_ext = {{(`DIV_XLEN-`DIV_WLEN){mag.op.is_signed & divisor_i[`DIV_WLEN-1]}},
               divisor_i[`DIV_WLEN-1:0]};
    end else begin
      a_ext = dividend_i;
      b_ext = divisor_i;
    end
  end

  assign a_neg = mag.op.is_signed & a_ext[`DIV_XLEN-1];
  assign b_neg = mag.op.is_signed & b_ext[`DIV_XLEN-1];

  // absolute values, the most negative value stays as an unsigned magnitude
  assign a_mag = a_neg ? -a_ext : a_ext;
  assign b_mag = b_neg ? -b_ext : b_ext;

  // shift in the next dividend bit and try the subtraction
  assign shifted = {rem_q, quo_q[`DIV_XLEN-1]};
  assign trial   = shifted - {1'b0, div_q};

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= div_status_pkg::CORE_IDLE;
      cnt_q   <= '0;
      q_neg_q <= 1'b0;
      r_neg_q <= 1'b0;
    end else begin
      case (state_q)
        div_status_pkg::CORE_IDLE: begin
          if (mag.start) begin
            state_q <= div_status_pkg::CORE_RUN;
            cnt_q   <= mag.op.is_word ? `DIV_CNT_W'(`DIV_WLEN) : `DIV_CNT_W'(`DIV_XLEN);
            // remainder takes the dividend sign, quotient the xor
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;
          end
        end
        div_status_pkg::CORE_RUN: begin
          if (cnt_q != '0) begin
            cnt_q <= cnt_q - 1'b1;
          end else begin
            state_q <= div_status_pkg::CORE_DONE;
          end
        end
        default: begin
          // done is shown for exactly this cycle
          state_q <= div_status_pkg::CORE_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == div_status_pkg::CORE_IDLE && mag.start) begin
      rem_q <= '0;
      div_q <= b_mag;
      // word dividend sits in the upper half so its msb shifts out first
      quo_q <= mag.op.is_word ? {a_mag[`DIV_WLEN-1:0], {(`DIV_XLEN-`DIV_WLEN){1'b0}}}
                              : a_mag;
    end else if (state_q == div_status_pkg::CORE_RUN) begin
      if (cnt_q != '0) begin
        // restore when the trial went negative
        if (!trial[`DIV_XLEN]) begin
          rem_q <= trial[`DIV_XLEN-1:0];
          quo_q <= {quo_q[`DIV_XLEN-2:0], 1'b1};
        end else begin
          rem_q <= shifted[`DIV_XLEN-1:0];
          quo_q <= {quo_q[`DIV_XLEN-2:0], 1'b0};
        end
      end else begin
        // final cycle applies the recorded signs in place
        quo_q <= q_neg_q ? -quo_q : quo_q;
        rem_q <= r_neg_q ? -rem_q : rem_q;
      end
    end
  end

  assign mag.busy      = (state_q != div_status_pkg::CORE_IDLE);
  assign mag.done      = (state_q == div_status_pkg::CORE_DONE);
  assign mag.quotient  = quo_q;
  assign mag.remainder = rem_q;

endmodule

//--- rtl/div_special_detect.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_special_detect (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  logic [`DIV_XLEN-1:0]          dividend_i,
  input  logic [`DIV_XLEN-1:0]          divisor_i,
  div_mag_if.detect                     mag,
  output div_status_pkg::special_kind_e special_kind_o,
  output logic [`DIV_XLEN-1:0]          fallback_dividend_o
);

  div_status_pkg::special_kind_e kind_d;
  div_status_pkg::special_kind_e kind_q;
  logic [`DIV_XLEN-1:0]          dividend_q;

  logic divisor_zero;
  logic dividend_min;
  logic divisor_ones;

  // compare at the operation width, upper half ignored for word ops
  always_comb begin
    if (mag.op.is_word) begin
      divisor_zero = (divisor_i[`DIV_WLEN-1:0] == '0);
      dividend_min = (dividend_i[`DIV_WLEN-1:0] == {1'b1, {(`DIV_WLEN-1){1'b0}}});
      divisor_ones = (divisor_i[`DIV_WLEN-1:0] == '1);
    end else begin
      divisor_zero = (divisor_i == '0);
      dividend_min = (dividend_i == {1'b1, {(`DIV_XLEN-1){1'b0}}});
      divisor_ones = (divisor_i == '1);
    end
  end

  // divide by zero wins, overflow only exists for signed ops
  always_comb begin
    if (divisor_zero) begin
      kind_d = div_status_pkg::SPECIAL_DIV_ZERO;
    end else if (mag.op.is_signed && dividend_min && divisor_ones) begin
      kind_d = div_status_pkg::SPECIAL_OVERFLOW;
    end else begin
      kind_d = div_status_pkg::SPECIAL_NONE;
    end
  end

  // classification holds until the next launch
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      kind_q <= div_status_pkg::SPECIAL_NONE;
    end else if (mag.start) begin
      kind_q <= kind_d;
    end
  end

  // the dividend is the remainder for div by zero and the quotient on overflow
  always_ff @(posedge clk) begin
    if (mag.start) begin
      dividend_q <= dividend_i;
    end
  end

  assign special_kind_o      = kind_q;
  assign fallback_dividend_o = dividend_q;

endmodule

//--- rtl/div_result_fix.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module div_result_fix (
  input  logic                          clk,
  input  logic                          rst_n_i,
  input  div_status_pkg::special_kind_e special_kind_i,
  input  logic [`DIV_XLEN-1:0]          fallback_dividend_i,
  div_mag_if.fix                        mag,
  output logic                          div_ready_o,
  output logic [`DIV_XLEN-1:0]          div_out_o,
  output logic [`DIV_XLEN-1:0]          rem_out_o
);

  // merged results before width handling
  logic [`DIV_XLEN-1:0] quo_sel;
  logic [`DIV_XLEN-1:0] rem_sel;

  // results after word sign extension
  logic [`DIV_XLEN-1:0] quo_ext;
  logic [`DIV_XLEN-1:0] rem_ext;

  // RISC-V defined results replace the core output in the special cases
  always_comb begin
    case (special_kind_i)
      div_status_pkg::SPECIAL_DIV_ZERO: begin
        // quotient all ones, remainder passes the dividend through
        quo_sel = '1;
        rem_sel = fallback_dividend_i;
      end
      div_status_pkg::SPECIAL_OVERFLOW: begin
        quo_sel = fallback_dividend_i;
        rem_sel = '0;
      end
      default: begin
        quo_sel = mag.quotient;
        rem_sel = mag.remainder;
      end
    endcase
  end

  // W ops return bit 31 copied into the upper half
  always_comb begin
    if (mag.op.is_word) begin
      quo_ext = {{(`DIV_XLEN-`DIV_WLEN){quo_sel[`DIV_WLEN-1]}}, quo_sel[`DIV_WLEN-1:0]};
      rem_ext = {{(`DIV_XLEN-`DIV_WLEN){rem_sel[`DIV_WLEN-1]}}, rem_sel[`DIV_WLEN-1:0]};
    end else begin
      quo_ext = quo_sel;
      rem_ext = rem_sel;
    end
  end

  // outputs hold until the next done replaces them
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      div_ready_o <= 1'b0;
      div_out_o   <= '0;
      rem_out_o   <= '0;
    end else begin
      // single-cycle ready, one cycle behind done
      div_ready_o <= mag.done;
      if (mag.done) begin
        div_out_o <= quo_ext;
        rem_out_o <= rem_ext;
      end
    end
  end

endmodule

//--- rtl/alu_div_top.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module alu_div_top (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 signed_valid_i,
  input  logic                 div32_valid_i,
  // dividend from rs1
  input  logic [`DIV_XLEN-1:0] sr1_data_i,
  // divisor from rs2
  input  logic [`DIV_XLEN-1:0] sr2_data_i,
  input  logic                 div_valid_i,
  output logic                 div_ready_o,
  output logic [`DIV_XLEN-1:0] div_out_o,
  output logic [`DIV_XLEN-1:0] rem_out_o
);

  div_op_pkg::div_op_t           op;
  logic                          start;
  div_status_pkg::special_kind_e special_kind;
  logic [`DIV_XLEN-1:0]          fallback_dividend;

  div_mag_if mag ();

  // request flags packed into one descriptor
  assign op.is_signed = signed_valid_i;
  assign op.is_word   = div32_valid_i;
  assign mag.op       = op;

  // launch only when idle
  // the ready cycle is also blocked since valid is still high there
  assign start     = div_valid_i & ~mag.busy & ~div_ready_o;
  assign mag.start = start;

  // shift-subtract datapath
  div_iter_core u_div_iter_core (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .dividend_i (sr1_data_i),
    .divisor_i  (sr2_data_i),
    .mag        (mag.core)
  );

  // div by zero and overflow classification, same operands
  div_special_detect u_div_special_detect (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .dividend_i          (sr1_data_i),
    .divisor_i           (sr2_data_i),
    .mag                 (mag.detect),
    .special_kind_o      (special_kind),
    .fallback_dividend_o (fallback_dividend)
  );

  // result merge, word extension and ready pulse
  div_result_fix u_div_result_fix (
    .clk                 (clk),
    .rst_n_i             (rst_n_i),
    .special_kind_i      (special_kind),
    .fallback_dividend_i (fallback_dividend),
    .mag                 (mag.fix),
    .div_ready_o         (div_ready_o),
    .div_out_o           (div_out_o),
    .rem_out_o           (rem_out_o)
  );

endmodule

//--- test/tb_alu_div_top.sv
`timescale 1ns/1ps
`include "div_settings.svh"

module tb_alu_div_top;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  // start to ready, counted in falling edges after the inputs are driven
  localparam int LAT_WORD     = 35;
  localparam int LAT_LONG     = 67;
  // upper bound on the requests issued by all tests together
  localparam int MAX_REQUESTS = 48;
  localparam int WAIT_LIMIT   = 200;
  localparam int WATCHDOG_NS  = (MAX_REQUESTS * (LAT_LONG + 2) + RESET_CYCLES + 200) * CLK_PERIOD;

  logic                 clk;
  logic                 rst_n_i;
  logic                 signed_valid_i;
  logic                 div32_valid_i;
  logic                 div_valid_i;
  logic [`DIV_XLEN-1:0] sr1_data_i;
  logic [`DIV_XLEN-1:0] sr2_data_i;
  logic                 div_ready_o;
  logic [`DIV_XLEN-1:0] div_out_o;
  logic [`DIV_XLEN-1:0] rem_out_o;

  int                   pass_count;
  int                   fail_count;
  int unsigned          lcg_state;
  // last result seen on the outputs, must hold until the next ready
  logic [`DIV_XLEN-1:0] last_quo;
  logic [`DIV_XLEN-1:0] last_rem;

  alu_div_top UUT (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .signed_valid_i (signed_valid_i),
    .div32_valid_i  (div32_valid_i),
    .sr1_data_i     (sr1_data_i),
    .sr2_data_i     (sr2_data_i),
    .div_valid_i    (div_valid_i),
    .div_ready_o    (div_ready_o),
    .div_out_o      (div_out_o),
    .rem_out_o      (rem_out_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // run limit sized from the longest possible request sequence
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, a request never completed", WATCHDOG_NS);
    $display("sim failed");
    $finish;
  end

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [`DIV_XLEN-1:0] rand64();
    logic [`DIV_XLEN-1:0] v;
    v[63:32] = next_rand();
    v[31:0]  = next_rand();
    return v;
  endfunction

  // RISC-V M results, packed as {quotient, remainder}
  function automatic logic [2*`DIV_XLEN-1:0] model_div(
    input  logic                          is_signed,
    input  logic                          is_word,
    input  logic [`DIV_XLEN-1:0]          a,
    input  logic [`DIV_XLEN-1:0]          b,
    output div_status_pkg::special_kind_e kind
  );
    logic [`DIV_WLEN-1:0] a_w;
    logic [`DIV_WLEN-1:0] b_w;
    logic [`DIV_WLEN-1:0] q_w;
    logic [`DIV_WLEN-1:0] r_w;
    logic [`DIV_XLEN-1:0] q;
    logic [`DIV_XLEN-1:0] r;
    kind = div_status_pkg::SPECIAL_NONE;
    if (is_word) begin
      // only the low word counts, results copy bit 31 upward
      a_w = a[`DIV_WLEN-1:0];
      b_w = b[`DIV_WLEN-1:0];
      if (b_w == '0) begin
        kind = div_status_pkg::SPECIAL_DIV_ZERO;
        q_w  = '1;
        r_w  = a_w;
      end else if (is_signed && a_w == {1'b1, {(`DIV_WLEN-1){1'b0}}} && b_w == '1) begin
        kind = div_status_pkg::SPECIAL_OVERFLOW;
        q_w  = a_w;
        r_w  = '0;
      end else if (is_signed) begin
        q_w = $signed(a_w) / $signed(b_w);
        r_w = $signed(a_w) % $signed(b_w);
      end else begin
        q_w = a_w / b_w;
        r_w = a_w % b_w;
      end
      q = {{(`DIV_XLEN-`DIV_WLEN){q_w[`DIV_WLEN-1]}}, q_w};
      r = {{(`DIV_XLEN-`DIV_WLEN){r_w[`DIV_WLEN-1]}}, r_w};
    end else begin
      if (b == '0) begin
        kind = div_status_pkg::SPECIAL_DIV_ZERO;
        q    = '1;
        r    = a;
      end else if (is_signed && a == {1'b1, {(`DIV_XLEN-1){1'b0}}} && b == '1) begin
        kind = div_status_pkg::SPECIAL_OVERFLOW;
        q    = a;
        r    = '0;
      end else if (is_signed) begin
        // truncating division, remainder takes the dividend sign
        q = $signed(a) / $signed(b);
        r = $signed(a) % $signed(b);
      end else begin
        q = a / b;
        r = a % b;
      end
    end
    return {q, r};
  endfunction

  task automatic check_data(input string name, input logic [`DIV_XLEN-1:0] exp,
                            input logic [`DIV_XLEN-1:0] act);
    if (act === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("[FAIL] %s expected 0x%016h got 0x%016h", name, exp, act);
    end
  endtask

  task automatic check_kind(input string name, input div_status_pkg::special_kind_e exp,
                            input div_status_pkg::special_kind_e act);
    if (act === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, act);
    end
  endtask

  task automatic check_handshake(input string what, input int exp, input int act);
    if (act == exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("%s was %0d but should have been %0d", what, act, exp);
    end
  endtask

  // called just after a falling edge, returns one falling edge after the ready pulse
  task automatic run_request(input logic is_signed, input logic is_word,
                             input logic [`DIV_XLEN-1:0] a, input logic [`DIV_XLEN-1:0] b,
                             input bit wiggle_valid);
    logic [2*`DIV_XLEN-1:0]        exp;
    div_status_pkg::special_kind_e exp_kind;
    logic [`DIV_XLEN-1:0]          held_quo;
    logic [`DIV_XLEN-1:0]          held_rem;
    int                            cycles;
    bit                            seen;
    exp            = model_div(is_signed, is_word, a, b, exp_kind);
    held_quo       = last_quo;
    held_rem       = last_rem;
    signed_valid_i = is_signed;
    div32_valid_i  = is_word;
    sr1_data_i     = a;
    sr2_data_i     = b;
    div_valid_i    = 1'b1;
    cycles         = 0;
    seen           = 1'b0;
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (div_ready_o) begin
        seen = 1'b1;
      end else begin
        // keep the first value that broke the hold
        if (held_quo === last_quo && held_rem === last_rem) begin
          held_quo = div_out_o;
          held_rem = rem_out_o;
        end
        // valid is ignored while busy
        if (wiggle_valid) begin
          div_valid_i = ~div_valid_i;
        end
      end
    end
    check_data("div_out_o held", last_quo, held_quo);
    check_data("rem_out_o held", last_rem, held_rem);
    if (!seen) begin
      fail_count++;
      $display("no ready pulse within %0d cycles of the request", WAIT_LIMIT);
    end else begin
      check_handshake("cycles from start to ready", is_word ? LAT_WORD : LAT_LONG, cycles);
      check_data("div_out_o", exp[2*`DIV_XLEN-1:`DIV_XLEN], div_out_o);
      check_data("rem_out_o", exp[`DIV_XLEN-1:0], rem_out_o);
      check_kind("special_kind", exp_kind, UUT.special_kind);
    end
    div_valid_i = 1'b0;
    last_quo    = div_out_o;
    last_rem    = rem_out_o;
    @(negedge clk);
    check_handshake("ready level one cycle after the pulse", 0, int'(div_ready_o));
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("test %-14s %s", name, (fail_count == fails_before) ? "ok" : "FAILED");
  endtask

  task automatic test_reset_state();
    int fails_before;
    fails_before = fail_count;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);
      check_handshake("ready level before any request", 0, int'(div_ready_o));
    end
    check_data("div_out_o", '0, div_out_o);
    check_data("rem_out_o", '0, rem_out_o);
    report_test("reset_state", fails_before);
  endtask

  task automatic test_long_ops();
    int fails_before;
    fails_before = fail_count;
    // alternate unsigned and signed, divisors of varied size
    for (int i = 0; i < 12; i++) begin
      run_request(i[0], 1'b0, rand64(), rand64() >> (next_rand() % 63), 1'b0);
    end
    run_request(1'b1, 1'b0, 64'd100, 64'd7, 1'b0);
    run_request(1'b1, 1'b0, -64'd100, 64'd7, 1'b0);
    run_request(1'b1, 1'b0, 64'd100, -64'd7, 1'b0);
    run_request(1'b1, 1'b0, -64'd100, -64'd7, 1'b0);
    run_request(1'b0, 1'b0, '1, 64'd3, 1'b0);
    report_test("long_ops", fails_before);
  endtask

  task automatic test_word_ops();
    int fails_before;
    fails_before = fail_count;
    // upper halves carry junk that must be ignored
    for (int i = 0; i < 12; i++) begin
      run_request(i[0], 1'b1, rand64(), {next_rand(), next_rand() >> (next_rand() % 31)}, 1'b0);
    end
    run_request(1'b1, 1'b1, 64'hDEAD_BEEF_FFFF_FFF9, 64'h1234_5678_0000_0002, 1'b0);
    run_request(1'b1, 1'b1, 64'h0000_0000_0000_0064, 64'h0000_0000_FFFF_FFF9, 1'b0);
    // unsigned quotient with bit 31 set still comes back sign extended
    run_request(1'b0, 1'b1, 64'h0000_0001_FFFF_FFFF, 64'hFFFF_FFFF_0000_0001, 1'b0);
    report_test("word_ops", fails_before);
  endtask

  task automatic test_div_zero();
    int fails_before;
    fails_before = fail_count;
    run_request(1'b0, 1'b0, rand64(), '0, 1'b0);
    run_request(1'b1, 1'b0, rand64(), '0, 1'b0);
    // word divisor zero only in the low half
    run_request(1'b0, 1'b1, rand64(), {next_rand(), 32'h0}, 1'b0);
    run_request(1'b1, 1'b1, 64'h1111_2222_8765_4321, 64'hFFFF_0000_0000_0000, 1'b0);
    report_test("div_zero", fails_before);
  endtask

  task automatic test_overflow();
    int fails_before;
    fails_before = fail_count;
    run_request(1'b1, 1'b0, 64'h8000_0000_0000_0000, '1, 1'b0);
    run_request(1'b1, 1'b1, 64'h5555_5555_8000_0000, 64'h0123_4567_FFFF_FFFF, 1'b0);
    // same operands unsigned are an ordinary division
    run_request(1'b0, 1'b0, 64'h8000_0000_0000_0000, '1, 1'b0);
    report_test("overflow", fails_before);
  endtask

  task automatic test_back_to_back();
    int fails_before;
    fails_before = fail_count;
    // each request is presented in the cycle after the previous ready
    for (int i = 0; i < 4; i++) begin
      run_request(i[1], i[0], rand64(), rand64() >> (next_rand() % 40), 1'b0);
    end
    run_request(1'b1, 1'b0, rand64(), rand64() >> 20, 1'b1);
    run_request(1'b1, 1'b1, rand64(), rand64() >> 10, 1'b1);
    report_test("back_to_back", fails_before);
  endtask

  initial begin
    rst_n_i        = 1'b0;
    signed_valid_i = 1'b0;
    div32_valid_i  = 1'b0;
    div_valid_i    = 1'b0;
    sr1_data_i     = '0;
    sr2_data_i     = '0;
    pass_count     = 0;
    fail_count     = 0;
    lcg_state      = 75;
    last_quo       = '0;
    last_rem       = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n_i = 1'b1;
    test_reset_state();
    test_long_ops();
    test_word_ops();
    test_div_zero();
    test_overflow();
    test_back_to_back();
    $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+rtl
rtl/div_op_pkg.sv
rtl/div_status_pkg.sv
rtl/div_mag_if.sv
rtl/div_iter_core.sv
rtl/div_special_detect.sv
rtl/div_result_fix.sv
rtl/alu_div_top.sv
test/tb_alu_div_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing -Wno-fatal --top-module tb_alu_div_top -f flist.f \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_alu_div_top > sim.log 2>&1
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
